//--- ntm_output_gate_pkg.sv
/*
  Output gate package
  Sizes, Q8.8 fixed-point types, feeder phase enum,
  lane column and sum arrays, lane operation struct
*/

`default_nettype none

package ntm_output_gate_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////

  localparam int GATE_L  = 4;  // Gate rows, lanes, length of h
  localparam int GATE_X  = 4;  // Input vector length
  localparam int GATE_RW = 4;  // 2 heads x word width 2, flattened

  // Fixed point
  localparam int FIX_FRAC = 8;    // Q8.8
  localparam int FIX_ONE  = 256;  // 1.0

  ////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////

  typedef logic signed [15:0] fix_t;  // Operands, weights, outputs
  typedef logic signed [31:0] acc_t;  // Lane accumulator, fix_t scaling

  typedef logic [2:0] beat_cnt_t;  // Covers longest phase
  typedef logic [1:0] lane_idx_t;  // Walks the lanes

  // One column of W, K or U, or the bias vector
  // Element l goes to lane l
  typedef fix_t [GATE_L-1:0] gate_col_t;

  // Lane results gathered at the top
  typedef acc_t [GATE_L-1:0] gate_sums_t;

  // Feeder states, in operand order
  typedef enum logic [2:0] {
    PH_IDLE = 3'd0,  // Waiting for START
    PH_WX   = 3'd1,  // W columns with x
    PH_KR   = 3'd2,  // K columns with r
    PH_UH   = 3'd3,  // U columns with h
    PH_BIAS = 3'd4   // Single bias beat
  } gate_phase_t;

  // Operation broadcast to every lane
  typedef struct packed {
    logic clear;  // Zero the accumulator
    logic mac;    // Add weight x vec
    fix_t vec;    // Shared vector element
  } lane_op_t;

endpackage

`default_nettype wire

//--- ntm_operand_feeder.sv
/*
  Operand feeder
  Phase FSM with beat counter, registered lane operation
  and weight column, sums_valid delay pipe
*/

`timescale 1ns/1ps
`default_nettype none

module ntm_operand_feeder (
  input  wire                                     CLK,
  input  wire                                     RST,
  input  wire                                     START,      // One-cycle pulse
  input  wire                                     IN_ENABLE,  // Beat strobe
  input  wire ntm_output_gate_pkg::fix_t          VEC_IN,
  input  wire ntm_output_gate_pkg::gate_col_t     COL_IN,
  output ntm_output_gate_pkg::gate_phase_t        PHASE,
  output ntm_output_gate_pkg::lane_op_t           lane_op,
  output ntm_output_gate_pkg::gate_col_t          lane_w,
  output logic                                    sums_valid
);

  import ntm_output_gate_pkg::*;

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  beat_cnt_t   beat_cnt;    // Beats taken in current phase
  beat_cnt_t   phase_last;  // Index of last beat of phase
  gate_phase_t phase_next;  // Phase after the last beat
  logic        beat_ok;     // Beat accepted this edge
  logic        last_beat;
  logic        bias_done;   // First stage of sums_valid pipe

  ////////////////////////////////////////////////////////////
  // Phase decode
  ////////////////////////////////////////////////////////////

  always_comb begin
    case (PHASE)
      PH_WX: begin
        phase_last = beat_cnt_t'(GATE_X - 1);
        phase_next = PH_KR;
      end
      PH_KR: begin
        phase_last = beat_cnt_t'(GATE_RW - 1);
        phase_next = PH_UH;
      end
      PH_UH: begin
        phase_last = beat_cnt_t'(GATE_L - 1);  // h has GATE_L elements
        phase_next = PH_BIAS;
      end
      default: begin  // Bias, and idle which never counts
        phase_last = '0;
        phase_next = PH_IDLE;
      end
    endcase
  end

  assign beat_ok   = IN_ENABLE && (PHASE != PH_IDLE);  // Idle beats dropped
  assign last_beat = beat_ok && (beat_cnt == phase_last);

  ////////////////////////////////////////////////////////////
  // FSM and lane operation
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      PHASE      <= PH_IDLE;
      beat_cnt   <= '0;
      lane_op    <= '0;
      bias_done  <= 1'b0;
      sums_valid <= 1'b0;
    end else begin
      lane_op.clear <= 1'b0;  // Single-cycle ops by default
      lane_op.mac   <= 1'b0;
      bias_done     <= 1'b0;
      sums_valid    <= bias_done;  // Second delay stage

      if (PHASE == PH_IDLE) begin
        if (START) begin  // START only counts here
          lane_op.clear <= 1'b1;
          beat_cnt      <= '0;
          PHASE         <= PH_WX;
        end
      end else if (beat_ok) begin
        lane_op.mac <= 1'b1;
        // Bias beat multiplies b by 1.0
        lane_op.vec <= (PHASE == PH_BIAS) ? fix_t'(FIX_ONE) : VEC_IN;
        if (last_beat) begin
          beat_cnt  <= '0;
          PHASE     <= phase_next;
          bias_done <= (PHASE == PH_BIAS);  // End of computation
        end else begin
          beat_cnt <= beat_cnt + 3'd1;
        end
      end
    end
  end

  // Weight column, only meaningful with mac
  always_ff @(posedge CLK) begin
    if (beat_ok) begin
      lane_w <= COL_IN;
    end
  end

endmodule

`default_nettype wire

//--- ntm_gate_lane.sv
/*
  Gate lane
  Q8.8 multiply-accumulate for one row of the output gate
*/

`timescale 1ns/1ps
`default_nettype none

module ntm_gate_lane (
  input  wire                                 CLK,
  input  wire                                 RST,
  input  wire ntm_output_gate_pkg::lane_op_t  lane_op,  // Shared by all lanes
  input  wire ntm_output_gate_pkg::fix_t      weight,   // This lane's column element
  output ntm_output_gate_pkg::acc_t           sum
);

  import ntm_output_gate_pkg::*;

  ////////////////////////////////////////////////////////////
  // Product
  ////////////////////////////////////////////////////////////

  acc_t prod;       // Q16.16 full product
  acc_t prod_fix;   // Rescaled to Q8.8 in 32 bits

  // Both operands signed, extended to 32 bits before multiply
  assign prod     = weight * lane_op.vec;
  assign prod_fix = prod >>> FIX_FRAC;  // Arithmetic, floors toward -inf

  ////////////////////////////////////////////////////////////
  // Accumulator
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      sum <= '0;
    end else if (lane_op.clear) begin
      sum <= '0;  // Start of computation
    end else if (lane_op.mac) begin
      sum <= sum + prod_fix;
    end
    // Otherwise hold, drain may still read it
  end

endmodule

`default_nettype wire

//--- ntm_logistic_drain.sv
/*
  Logistic drain
  Captures all lane sums, applies the saturating
  logistic and serializes one element per cycle
*/

`timescale 1ns/1ps
`default_nettype none

module ntm_logistic_drain (
  input  wire                                   CLK,
  input  wire                                   RST,
  input  wire                                   sums_valid,  // Capture strobe
  input  wire ntm_output_gate_pkg::gate_sums_t  sums,
  output ntm_output_gate_pkg::fix_t             O_OUT,
  output logic                                  O_OUT_ENABLE,
  output logic                                  READY         // With last element
);

  import ntm_output_gate_pkg::*;

  ////////////////////////////////////////////////////////////
  // Logistic
  ////////////////////////////////////////////////////////////

  // 0.5 + a/4, clamped to [0, 1]
  function automatic fix_t logistic(input acc_t a);
    acc_t lin;
    begin
      lin = acc_t'(FIX_ONE / 2) + (a >>> 2);
      if (a >= acc_t'(2 * FIX_ONE)) begin
        logistic = fix_t'(FIX_ONE);  // Upper knee
      end else if (a <= -acc_t'(2 * FIX_ONE)) begin
        logistic = '0;  // Lower knee
      end else begin
        logistic = fix_t'(lin);  // Always fits in 0..255 here
      end
    end
  endfunction

  ////////////////////////////////////////////////////////////
  // Capture and walk
  ////////////////////////////////////////////////////////////

  gate_sums_t sums_q;    // Held copy, lanes may restart
  lane_idx_t  idx;       // Next lane to emit
  logic       busy;      // Emission in progress
  logic       idx_last;
  acc_t       cur_sum;

  assign idx_last = (idx == lane_idx_t'(GATE_L - 1));
  assign cur_sum  = sums_q[idx];

  always_ff @(posedge CLK) begin
    if (sums_valid) begin
      sums_q <= sums;
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy         <= 1'b0;
      idx          <= '0;
      O_OUT_ENABLE <= 1'b0;
      READY        <= 1'b0;
    end else begin
      O_OUT_ENABLE <= busy;
      READY        <= busy && idx_last;  // Flags final element
      if (sums_valid) begin
        busy <= 1'b1;
        idx  <= '0;  // Lane 0 first
      end else if (busy) begin
        idx <= idx + 2'd1;
        if (idx_last) begin
          busy <= 1'b0;
        end
      end
    end
  end

  // Output data register, paired with O_OUT_ENABLE
  always_ff @(posedge CLK) begin
    if (busy) begin
      O_OUT <= logistic(cur_sum);
    end
  end

endmodule

`default_nettype wire

//--- ntm_output_gate_vector.sv
/*
  Output gate top level
  Operand feeder, GATE_L gate lanes, logistic drain
*/

`timescale 1ns/1ps
`default_nettype none

module ntm_output_gate_vector (
  input  wire                                 CLK,
  input  wire                                 RST,
  input  wire                                 START,
  input  wire                                 IN_ENABLE,
  input  wire ntm_output_gate_pkg::fix_t      VEC_IN,   // x, r, h element
  input  wire ntm_output_gate_pkg::gate_col_t COL_IN,   // W, K, U column or b
  output ntm_output_gate_pkg::gate_phase_t    PHASE,    // Next operand kind
  output ntm_output_gate_pkg::fix_t           O_OUT,
  output logic                                O_OUT_ENABLE,
  output logic                                READY
);

  import ntm_output_gate_pkg::*;

  ////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////

  wire lane_op_t   lane_op;     // Broadcast operation
  wire gate_col_t  lane_w;      // Per-lane weight
  wire             sums_valid;  // Feeder to drain
  wire gate_sums_t sums;        // Packed lane results

  // Feeder
  ntm_operand_feeder u_ntm_operand_feeder (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .IN_ENABLE  (IN_ENABLE),
    .VEC_IN     (VEC_IN),
    .COL_IN     (COL_IN),
    .PHASE      (PHASE),
    .lane_op    (lane_op),
    .lane_w     (lane_w),
    .sums_valid (sums_valid)
  );

  ////////////////////////////////////////////////////////////
  // Lanes, one per gate row
  ////////////////////////////////////////////////////////////

  for (genvar l = 0; l < GATE_L; l++) begin : gen_lane
    ntm_gate_lane u_ntm_gate_lane (
      .CLK     (CLK),
      .RST     (RST),
      .lane_op (lane_op),
      .weight  (lane_w[l]),  // Row l of the current column
      .sum     (sums[l])
    );
  end

  // Drain, serializes o(0) .. o(GATE_L-1)
  ntm_logistic_drain u_ntm_logistic_drain (
    .CLK          (CLK),
    .RST          (RST),
    .sums_valid   (sums_valid),
    .sums         (sums),
    .O_OUT        (O_OUT),
    .O_OUT_ENABLE (O_OUT_ENABLE),
    .READY        (READY)
  );

endmodule

`default_nettype wire

//--- tb_ntm_output_gate.sv
/*
  Output gate testbench
  Clock, reset, operand stimulus, reference gate model,
  output monitor with typed compare tasks, watchdog
*/

`timescale 1ns/1ps
`default_nettype none

module tb_ntm_output_gate;

  import ntm_output_gate_pkg::*;

  ////////////////////////////////////////////////////////////
  // Sizes and limits
  ////////////////////////////////////////////////////////////

  localparam int NUM_TESTS    = 12;  // run_gate calls below
  localparam int TEST_BEATS   = GATE_X + GATE_RW + GATE_L + 1;
  localparam int WATCHDOG_CYC = NUM_TESTS * (TEST_BEATS + GATE_L + 10) + 50;

  // Operand sets indexed by the beat within a phase
  typedef fix_t      [GATE_X-1:0]  xvec_t;
  typedef fix_t      [GATE_RW-1:0] rvec_t;
  typedef fix_t      [GATE_L-1:0]  hvec_t;
  typedef gate_col_t [GATE_X-1:0]  wmat_t;   // Column j pairs with x[j]
  typedef gate_col_t [GATE_RW-1:0] kmat_t;
  typedef gate_col_t [GATE_L-1:0]  umat_t;

  ////////////////////////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////////////////////////

  logic        CLK;
  logic        RST;
  logic        START;
  logic        IN_ENABLE;
  fix_t        VEC_IN;
  gate_col_t   COL_IN;
  gate_phase_t PHASE;
  fix_t        O_OUT;
  logic        O_OUT_ENABLE;
  logic        READY;

  // Current operands
  xvec_t     x_v;
  rvec_t     r_v;
  hvec_t     h_v;
  wmat_t     w_m;
  kmat_t     k_m;
  umat_t     u_m;
  gate_col_t b_v;

  fix_t exp_q[$];        // Expected O_OUT in lane order
  int   seed = 4826;
  int   value_errors = 0;
  int   other_errors = 0;
  int   out_idx = 0;     // Lane of next output
  int   out_cnt = 0;

  ntm_output_gate_vector u_ntm_output_gate_vector (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .IN_ENABLE    (IN_ENABLE),
    .VEC_IN       (VEC_IN),
    .COL_IN       (COL_IN),
    .PHASE        (PHASE),
    .O_OUT        (O_OUT),
    .O_OUT_ENABLE (O_OUT_ENABLE),
    .READY        (READY)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;  // 100 ns period
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Q8.8 product floored back to Q8.8
  function automatic acc_t product_q88(input fix_t w, input fix_t v);
    acc_t p;
    p = acc_t'(w) * acc_t'(v);
    return p >>> FIX_FRAC;
  endfunction

  // 0.5 + a/4 with knees at +-2.0
  function automatic fix_t saturate_logistic(input acc_t a);
    if (a >= acc_t'(2 * FIX_ONE)) begin
      return fix_t'(FIX_ONE);
    end else if (a <= acc_t'(-2 * FIX_ONE)) begin
      return '0;
    end
    return fix_t'(acc_t'(FIX_ONE / 2) + (a >>> 2));
  endfunction

  function automatic gate_col_t gate_model(input xvec_t x, input wmat_t w,
                                           input rvec_t r, input kmat_t k,
                                           input hvec_t h, input umat_t u,
                                           input gate_col_t b);
    gate_col_t o;
    acc_t      a;
    int        j;
    int        l;
    for (l = 0; l < GATE_L; l++) begin
      a = '0;
      for (j = 0; j < GATE_X; j++) a = a + product_q88(w[j][l], x[j]);   // W x
      for (j = 0; j < GATE_RW; j++) a = a + product_q88(k[j][l], r[j]);  // K r
      for (j = 0; j < GATE_L; j++) a = a + product_q88(u[j][l], h[j]);   // U h
      a    = a + acc_t'(b[l]);  // b times 1.0 is exact
      o[l] = saturate_logistic(a);
    end
    return o;
  endfunction

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic compare_fix(input string name, input fix_t exp, input fix_t act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED at %0t ns: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic compare_phase(input string name, input gate_phase_t exp,
                               input gate_phase_t act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED at %0t ns: %s expected %s got %s (%0d)", $time, name,
               exp.name(), act.name(), act);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus helpers entered 10 ns after an edge
  ////////////////////////////////////////////////////////////

  // Uniform in [-2.0, 2.0]
  task automatic rand_fix(output fix_t v);
    v = fix_t'($random(seed) % 513);
  endtask

  task automatic randomize_operands();
    int j;
    int l;
    for (j = 0; j < GATE_X; j++) rand_fix(x_v[j]);
    for (j = 0; j < GATE_RW; j++) rand_fix(r_v[j]);
    for (j = 0; j < GATE_L; j++) rand_fix(h_v[j]);
    for (l = 0; l < GATE_L; l++) begin
      for (j = 0; j < GATE_X; j++) rand_fix(w_m[j][l]);
      for (j = 0; j < GATE_RW; j++) rand_fix(k_m[j][l]);
      for (j = 0; j < GATE_L; j++) rand_fix(u_m[j][l]);
      rand_fix(b_v[l]);
    end
  endtask

  // Vectors at 2.0 and one weight value per lane for the clamps
  task automatic fill_by_lane(input gate_col_t wl, input gate_col_t bl);
    int j;
    for (j = 0; j < GATE_X; j++) x_v[j] = fix_t'(2 * FIX_ONE);
    for (j = 0; j < GATE_RW; j++) r_v[j] = fix_t'(2 * FIX_ONE);
    for (j = 0; j < GATE_L; j++) h_v[j] = fix_t'(2 * FIX_ONE);
    for (j = 0; j < GATE_X; j++) w_m[j] = wl;
    for (j = 0; j < GATE_RW; j++) k_m[j] = wl;
    for (j = 0; j < GATE_L; j++) u_m[j] = wl;
    b_v = bl;
  endtask

  task automatic send_beat(input gate_phase_t ph, input fix_t v, input gate_col_t c);
    compare_phase("PHASE", ph, PHASE);  // Host's view of next operand
    IN_ENABLE = 1'b1;
    VEC_IN    = v;
    COL_IN    = c;
    @(posedge CLK);
    #10;
    IN_ENABLE = 1'b0;
  endtask

  // Idle cycles with junk on the data inputs
  task automatic hold_gap(input int cycles, input logic with_start);
    int i;
    for (i = 0; i < cycles; i++) begin
      START  = with_start && (i == 0);  // Should be ignored mid-run
      VEC_IN = '1;
      COL_IN = '1;
      @(posedge CLK);
      #10;
      START = 1'b0;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #10;
    end
  endtask

  // One full computation on the current operands
  task automatic run_gate(input int gap, input logic mid_start);
    gate_col_t exp_o;
    int        j;
    int        n;
    exp_o = gate_model(x_v, w_m, r_v, k_m, h_v, u_m, b_v);
    for (j = 0; j < GATE_L; j++) exp_q.push_back(exp_o[j]);
    compare_phase("PHASE", PH_IDLE, PHASE);
    START = 1'b1;
    @(posedge CLK);
    #10;
    START = 1'b0;
    n = 0;
    for (j = 0; j < GATE_X; j++) begin
      send_beat(PH_WX, x_v[j], w_m[j]);
      hold_gap(gap, mid_start && (n == GATE_X + 1));
      n++;
    end
    for (j = 0; j < GATE_RW; j++) begin
      send_beat(PH_KR, r_v[j], k_m[j]);
      hold_gap(gap, mid_start && (n == GATE_X + 1));  // START lands in PH_KR
      n++;
    end
    for (j = 0; j < GATE_L; j++) begin
      send_beat(PH_UH, h_v[j], u_m[j]);
      hold_gap(gap, 1'b0);
    end
    send_beat(PH_BIAS, x_v[0], b_v);  // VEC_IN replaced by 1.0
    compare_phase("PHASE", PH_IDLE, PHASE);
  endtask

  ////////////////////////////////////////////////////////////
  // Output monitor sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge CLK) begin
    if (!RST && O_OUT_ENABLE) begin
      if (exp_q.size() == 0) begin
        other_errors++;
        $display("ERROR at %0t ns: O_OUT_ENABLE high with no result expected", $time);
      end else begin
        compare_fix("O_OUT", exp_q.pop_front(), O_OUT);
        compare_bit("READY", out_idx == GATE_L - 1, READY);  // Last lane only
        out_idx = (out_idx + 1) % GATE_L;
        out_cnt++;
      end
    end else if (!RST && READY) begin
      other_errors++;
      $display("ERROR at %0t ns: READY high without an output element", $time);
    end
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYC) @(posedge CLK);
    $display("ERROR: watchdog expired, the test sequence did not complete");
    $display("Finished with errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    RST       = 1'b1;
    START     = 1'b0;
    IN_ENABLE = 1'b0;
    VEC_IN    = '0;
    COL_IN    = '0;
    repeat (5) @(posedge CLK);
    #10;
    RST = 1'b0;

    // Idle after reset with stray beats dropped
    repeat (4) begin
      compare_phase("PHASE", PH_IDLE, PHASE);
      compare_bit("O_OUT_ENABLE", 1'b0, O_OUT_ENABLE);
      compare_bit("READY", 1'b0, READY);
      IN_ENABLE = 1'b1;
      VEC_IN    = fix_t'(FIX_ONE);
      COL_IN    = '1;
      @(posedge CLK);
      #10;
    end
    IN_ENABLE = 1'b0;

    // Random computations with the drain idle in between
    repeat (6) begin
      randomize_operands();
      run_gate(0, 1'b0);
      idle_cycles(GATE_L + 4);
    end

    // Clamps at +48.0 and -48.0, then zero and 1.0 on lanes 2 and 3
    fill_by_lane({16'sd0, 16'sd0, -16'sd512, 16'sd512}, {16'sd256, 16'sd0, 16'sd0, 16'sd0});
    run_gate(0, 1'b0);
    idle_cycles(GATE_L + 4);
    // Bias only at and just inside the knees
    fill_by_lane('0, {-16'sd511, 16'sd511, -16'sd512, 16'sd512});
    run_gate(0, 1'b0);
    idle_cycles(GATE_L + 4);

    // Two idle cycles between all beats
    randomize_operands();
    run_gate(2, 1'b0);
    idle_cycles(GATE_L + 4);

    // Second computation starts while the drain emits
    randomize_operands();
    run_gate(0, 1'b0);
    randomize_operands();
    run_gate(0, 1'b0);
    idle_cycles(GATE_L + 4);

    // START during PH_KR is ignored
    randomize_operands();
    run_gate(1, 1'b1);

    idle_cycles(GATE_L + 8);
    if (exp_q.size() != 0 || out_cnt != NUM_TESTS * GATE_L) begin
      other_errors++;
      $display("ERROR: %0d outputs received, %0d results never arrived",
               out_cnt, exp_q.size());
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- ntm_output_gate.f
ntm_output_gate_pkg.sv
ntm_operand_feeder.sv
ntm_gate_lane.sv
ntm_logistic_drain.sv
ntm_output_gate_vector.sv
tb_ntm_output_gate.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the output gate testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_ntm_output_gate \
  -f ntm_output_gate.f -o sim_ntm_output_gate || { echo "Build failed"; exit 1; }

out=$(./obj_dir/sim_ntm_output_gate)
printf '%s\n' "$out"

printf '%s\n' "$out" | grep -qx "Finished with no errors" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
